// File: mips_pkg.sv
// shared types for the pipelined mips core
// word, word address, register index and byte lane mask
// primary opcode, special funct, alu and memory operation encodings
// stage structs carried between the pipeline registers
`default_nettype none

package mips_pkg;

   typedef logic [31:0] word_t;
   // byte address bits 31 to 2
   typedef logic [29:0] word_addr_t;
   typedef logic [4:0]  reg_idx_t;
   // bit k enables data bits 8k+7 to 8k, little-endian lanes
   typedef logic [3:0]  byte_en_t;

   // reset pc, start of the text segment
   localparam word_t text_start = 32'h0040_0000;

   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_SLTIU   = 6'h0b,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_SB      = 6'h28,
      OP_SH      = 6'h29,
      OP_SW      = 6'h2b
   } opcode_e;

   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SLLV    = 6'h04,
      FN_SRLV    = 6'h06,
      FN_SRAV    = 6'h07,
      FN_SYSCALL = 6'h0c,
      FN_ADDU    = 6'h21,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a,
      FN_SLTU    = 6'h2b
   } funct_e;

   // add is zero so a cleared request is a plain add
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV, ALU_LUI
   } alu_op_e;

   typedef enum logic [3:0] {
      MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
   } mem_op_e;

   // decode to execute
   typedef struct packed {
      alu_op_e  alu_op;
      mem_op_e  mem_op;
      logic     use_imm;
      logic     reg_write;
      logic     halt;
      reg_idx_t dest;
      word_t    rs_data;
      word_t    rt_data;
      // already sign or zero extended
      word_t    imm;
   } ex_req_t;

   // execute to memory
   typedef struct packed {
      mem_op_e  mem_op;
      logic     reg_write;
      logic     halt;
      reg_idx_t dest;
      // alu result or byte address
      word_t    result;
      word_t    store_data;
   } mem_req_t;

   // memory to register file
   typedef struct packed {
      logic     write;
      logic     halt;
      reg_idx_t dest;
      word_t    data;
   } wb_req_t;

endpackage

`default_nettype wire

// File: mips_fetch.sv
// fetch stage of the pipelined mips core
// pc register and the fetch to decode instruction register
`timescale 1ns/100ps
`default_nettype none

module mips_fetch (
   input  logic                 clk,
   input  logic                 rst_b,
   input  logic                 stall,
   input  mips_pkg::word_t      inst,
   output mips_pkg::word_addr_t inst_addr,
   output mips_pkg::word_t      dec_inst
);

   import mips_pkg::*;

   // pc kept as a word address
   word_addr_t pc;

   // instruction memory reads combinationally from the current pc
   assign inst_addr = pc;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc       <= text_start[31:2];
         // all-zero word decodes as sll r0 which changes nothing
         dec_inst <= '0;
      end else if (!stall) begin
         // one word per cycle
         pc       <= pc + 1'b1;
         dec_inst <= inst;
      end
      // stalled so pc and instruction hold and the same word is refetched
   end

endmodule

`default_nettype wire

// File: mips_decode.sv
// decode stage of the pipelined mips core
// field extraction and control decode
// read-after-write stall against execute and memory, syscall drain
// decode to execute pipeline register
`timescale 1ns/100ps
`default_nettype none

module mips_decode (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::word_t    dec_inst,
   output mips_pkg::reg_idx_t rs_idx,
   output mips_pkg::reg_idx_t rt_idx,
   input  mips_pkg::word_t    rs_data,
   input  mips_pkg::word_t    rt_data,
   input  mips_pkg::mem_req_t mem_req,
   output logic               stall,
   output mips_pkg::ex_req_t  ex_req
);

   import mips_pkg::*;

   opcode_e  opcode;
   funct_e   funct;
   reg_idx_t rd_idx;
   alu_op_e  alu_op;
   mem_op_e  mem_op;
   logic     reg_write;
   logic     is_syscall;
   logic     zero_ext;
   logic     hazard;
   logic     draining;
   ex_req_t  next_req;

   // true when idx is still waiting on a write from execute or memory
   function automatic logic busy(input reg_idx_t idx);
      logic ex_hit;
      logic mem_hit;
      ex_hit  = ex_req.reg_write && (ex_req.dest == idx);
      mem_hit = mem_req.reg_write && (mem_req.dest == idx);
      return (idx != '0) && (ex_hit || mem_hit);
   endfunction

   // instruction fields
   assign opcode = opcode_e'(dec_inst[31:26]);
   assign rs_idx = dec_inst[25:21];
   assign rt_idx = dec_inst[20:16];
   assign rd_idx = dec_inst[15:11];
   assign funct  = funct_e'(dec_inst[5:0]);

   // logical immediates zero extend and everything else sign extends
   assign zero_ext = opcode inside {OP_ANDI, OP_ORI, OP_XORI};

   always_comb begin
      alu_op     = ALU_ADD;
      mem_op     = MEM_NONE;
      reg_write  = 1'b1;
      is_syscall = 1'b0;
      case (opcode)
         OP_SPECIAL: begin
            case (funct)
               FN_SLL:  alu_op = ALU_SLL;
               FN_SRL:  alu_op = ALU_SRL;
               FN_SRA:  alu_op = ALU_SRA;
               FN_SLLV: alu_op = ALU_SLLV;
               FN_SRLV: alu_op = ALU_SRLV;
               FN_SRAV: alu_op = ALU_SRAV;
               FN_ADDU: alu_op = ALU_ADD;
               FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_NOR:  alu_op = ALU_NOR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_SLTU: alu_op = ALU_SLTU;
               FN_SYSCALL: begin
                  reg_write  = 1'b0;
                  is_syscall = 1'b1;
               end
               // unknown funct becomes a no-op
               default: reg_write = 1'b0;
            endcase
         end
         OP_ADDIU: alu_op = ALU_ADD;
         OP_SLTI:  alu_op = ALU_SLT;
         OP_SLTIU: alu_op = ALU_SLTU;
         OP_ANDI:  alu_op = ALU_AND;
         OP_ORI:   alu_op = ALU_OR;
         OP_XORI:  alu_op = ALU_XOR;
         OP_LUI:   alu_op = ALU_LUI;
         // loads and stores keep alu add for base plus offset
         OP_LB:    mem_op = MEM_LB;
         OP_LH:    mem_op = MEM_LH;
         OP_LW:    mem_op = MEM_LW;
         OP_LBU:   mem_op = MEM_LBU;
         OP_LHU:   mem_op = MEM_LHU;
         OP_SB:    mem_op = MEM_SB;
         OP_SH:    mem_op = MEM_SH;
         OP_SW:    mem_op = MEM_SW;
         default:  reg_write = 1'b0;
      endcase
      // stores write memory only
      if (mem_op inside {MEM_SB, MEM_SH, MEM_SW}) begin
         reg_write = 1'b0;
      end
   end

   // writeback is covered by the register file bypass
   always_comb begin
      hazard = busy(rs_idx) || busy(rt_idx);
   end
   // after syscall nothing more leaves decode
   assign stall  = hazard || draining;

   always_comb begin
      next_req.alu_op    = alu_op;
      next_req.mem_op    = mem_op;
      // r-type uses rt and gets shamt through imm bits 10 to 6
      next_req.use_imm   = (opcode != OP_SPECIAL);
      next_req.reg_write = reg_write;
      next_req.halt      = is_syscall;
      next_req.dest      = (opcode == OP_SPECIAL) ? rd_idx : rt_idx;
      next_req.rs_data   = rs_data;
      next_req.rt_data   = rt_data;
      next_req.imm       = zero_ext ? {16'h0000, dec_inst[15:0]}
                                    : {{16{dec_inst[15]}}, dec_inst[15:0]};
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         draining <= 1'b0;
         ex_req   <= '0;
      end else begin
         // sticky once the syscall has been issued
         if (!stall && is_syscall) begin
            draining <= 1'b1;
         end
         // bubble while stalled or draining
         if (stall) begin
            ex_req <= '0;
         end else begin
            ex_req <= next_req;
         end
      end
   end

endmodule

`default_nettype wire

// File: mips_regfile.sv
// 32 by 32-bit register file for the pipelined mips core
// two asynchronous read ports with write-through bypass, one write port
`timescale 1ns/100ps
`default_nettype none

module mips_regfile (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs_idx,
   input  mips_pkg::reg_idx_t rt_idx,
   output mips_pkg::word_t    rs_data,
   output mips_pkg::word_t    rt_data,
   input  mips_pkg::wb_req_t  wb_req
);

   import mips_pkg::*;

   word_t regs [32];

   // r0 reads zero and a same-cycle write is seen by the reader
   function automatic word_t read_port(input reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end else if (wb_req.write && (wb_req.dest == idx)) begin
         return wb_req.data;
      end
      return regs[idx];
   endfunction

   always_comb begin
      rs_data = read_port(rs_idx);
      rt_data = read_port(rt_idx);
   end

   // programs start with every register at zero
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_req.write && (wb_req.dest != '0)) begin
         regs[wb_req.dest] <= wb_req.data;
      end
   end

endmodule

`default_nettype wire

// File: mips_execute.sv
// execute stage of the pipelined mips core
// operand select, alu and the execute to memory register
`timescale 1ns/100ps
`default_nettype none

module mips_execute (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::ex_req_t  ex_req,
   output mips_pkg::mem_req_t mem_req
);

   import mips_pkg::*;

   word_t       op_a;
   word_t       op_b;
   logic [4:0]  shamt;
   logic [4:0]  vshamt;
   word_t       result;

   assign op_a   = ex_req.rs_data;
   // immediate forms replace rt
   assign op_b   = ex_req.use_imm ? ex_req.imm : ex_req.rt_data;
   // fixed shifts take shamt from the instruction, variable ones from rs
   assign shamt  = ex_req.imm[10:6];
   assign vshamt = ex_req.rs_data[4:0];

   always_comb begin
      case (ex_req.alu_op)
         ALU_SUB:  result = op_a - op_b;
         ALU_AND:  result = op_a & op_b;
         ALU_OR:   result = op_a | op_b;
         ALU_XOR:  result = op_a ^ op_b;
         ALU_NOR:  result = ~(op_a | op_b);
         ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
         ALU_SLTU: result = {31'b0, op_a < op_b};
         // shifts always act on rt
         ALU_SLL:  result = ex_req.rt_data << shamt;
         ALU_SRL:  result = ex_req.rt_data >> shamt;
         ALU_SRA:  result = $unsigned($signed(ex_req.rt_data) >>> shamt);
         ALU_SLLV: result = ex_req.rt_data << vshamt;
         ALU_SRLV: result = ex_req.rt_data >> vshamt;
         ALU_SRAV: result = $unsigned($signed(ex_req.rt_data) >>> vshamt);
         ALU_LUI:  result = {ex_req.imm[15:0], 16'h0000};
         // add, also the load and store address
         default:  result = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         mem_req <= '0;
      end else begin
         mem_req.mem_op     <= ex_req.mem_op;
         mem_req.reg_write  <= ex_req.reg_write;
         mem_req.halt       <= ex_req.halt;
         mem_req.dest       <= ex_req.dest;
         mem_req.result     <= result;
         mem_req.store_data <= ex_req.rt_data;
      end
   end

endmodule

`default_nettype wire

// File: mips_memory_stage.sv
// memory stage of the pipelined mips core
// store lane placement and write mask, load byte and halfword extraction
// memory to writeback register and the sticky halted flag
`timescale 1ns/100ps
`default_nettype none

module mips_memory_stage (
   input  logic                 clk,
   input  logic                 rst_b,
   input  mips_pkg::mem_req_t   mem_req,
   output mips_pkg::word_addr_t mem_addr,
   output mips_pkg::word_t      mem_data_in,
   output mips_pkg::byte_en_t   mem_write_en,
   input  mips_pkg::word_t      mem_data_out,
   output mips_pkg::wb_req_t    wb_req,
   output logic                 halted
);

   import mips_pkg::*;

   logic [1:0] offset;
   word_t      lane_data;
   word_t      load_data;
   logic       is_load;
   wb_req_t    next_wb;

   assign mem_addr = mem_req.result[31:2];
   // byte within the word selects the lane
   assign offset   = mem_req.result[1:0];

   always_comb begin
      // move the low byte or halfword of rt up into its lane
      mem_data_in  = mem_req.store_data << {offset, 3'b000};
      mem_write_en = 4'b0000;
      case (mem_req.mem_op)
         MEM_SB: mem_write_en = 4'b0001 << offset;
         MEM_SH: mem_write_en = offset[1] ? 4'b1100 : 4'b0011;
         MEM_SW: begin
            mem_write_en = 4'b1111;
            mem_data_in  = mem_req.store_data;
         end
         default: mem_write_en = 4'b0000;
      endcase
   end

   // addressed lane brought down to bit 0
   assign lane_data = mem_data_out >> {offset, 3'b000};
   assign is_load   = mem_req.mem_op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};

   always_comb begin
      case (mem_req.mem_op)
         MEM_LB:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};
         MEM_LH:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};
         MEM_LBU: load_data = {24'h000000, lane_data[7:0]};
         MEM_LHU: load_data = {16'h0000, lane_data[15:0]};
         // lw takes the word as it is
         default: load_data = mem_data_out;
      endcase
   end

   assign next_wb.write = mem_req.reg_write;
   assign next_wb.halt  = mem_req.halt;
   assign next_wb.dest  = mem_req.dest;
   assign next_wb.data  = is_load ? load_data : mem_req.result;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb_req <= '0;
         halted <= 1'b0;
      end else begin
         wb_req <= next_wb;
         // rises with the syscall entering writeback and stays until reset
         if (mem_req.halt) begin
            halted <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: mips_core.sv
// top level of the five-stage pipelined mips core
// fetch, decode, execute and memory stages with the register file
// separate instruction and data memory ports
`timescale 1ns/100ps
`default_nettype none

module mips_core (
   input  logic                 clk,
   input  logic                 rst_b,
   output mips_pkg::word_addr_t inst_addr,
   input  mips_pkg::word_t      inst,
   output mips_pkg::word_addr_t mem_addr,
   output mips_pkg::word_t      mem_data_in,
   output mips_pkg::byte_en_t   mem_write_en,
   input  mips_pkg::word_t      mem_data_out,
   output logic                 halted
);

   import mips_pkg::*;

   logic     stall;
   word_t    dec_inst;
   reg_idx_t rs_idx;
   reg_idx_t rt_idx;
   word_t    rs_data;
   word_t    rt_data;
   ex_req_t  ex_req;
   mem_req_t mem_req;
   wb_req_t  wb_req;

   mips_fetch i_fetch (
      .clk       (clk),
      .rst_b     (rst_b),
      .stall     (stall),
      .inst      (inst),
      .inst_addr (inst_addr),
      .dec_inst  (dec_inst)
   );

   // mem_req also returns to decode for the hazard check
   mips_decode i_decode (
      .clk      (clk),
      .rst_b    (rst_b),
      .dec_inst (dec_inst),
      .rs_idx   (rs_idx),
      .rt_idx   (rt_idx),
      .rs_data  (rs_data),
      .rt_data  (rt_data),
      .mem_req  (mem_req),
      .stall    (stall),
      .ex_req   (ex_req)
   );

   mips_regfile i_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_idx  (rs_idx),
      .rt_idx  (rt_idx),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .wb_req  (wb_req)
   );

   mips_execute i_execute (
      .clk     (clk),
      .rst_b   (rst_b),
      .ex_req  (ex_req),
      .mem_req (mem_req)
   );

   mips_memory_stage i_memory (
      .clk          (clk),
      .rst_b        (rst_b),
      .mem_req      (mem_req),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .mem_data_out (mem_data_out),
      .wb_req       (wb_req),
      .halted       (halted)
   );

endmodule

`default_nettype wire

// File: mips_core_assertions.sv
// concurrent checks on the mips core top-level ports
// halted stays set, no stores after halt, legal lane masks, pc step
`timescale 1ns/100ps
`default_nettype none

module mips_core_assertions (
   input logic                 clk,
   input logic                 rst_b,
   input mips_pkg::word_addr_t inst_addr,
   input mips_pkg::byte_en_t   mem_write_en,
   input logic                 halted
);

   import mips_pkg::*;

   // only reset clears halted
   halted_sticky: assert property (@(posedge clk) disable iff (!rst_b) halted |=> halted)
      else $error("halted fell while out of reset");

   // drained pipeline writes nothing
   no_store_halted: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> (mem_write_en == 4'h0))
      else $error("store while halted");

   // one lane, an aligned half or the whole word
   lane_mask_legal: assert property (@(posedge clk) disable iff (!rst_b)
      mem_write_en inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf})
      else $error("illegal lane mask %b", mem_write_en);

   // pc holds on a stall, otherwise moves one word
   pc_step: assert property (@(posedge clk) disable iff (!rst_b)
      (inst_addr == $past(inst_addr)) ||
      (inst_addr == word_addr_t'($past(inst_addr) + 30'd1)))
      else $error("instruction address jumped to %h", inst_addr);

endmodule

`default_nettype wire

// File: tb_mips_core.sv
// testbench for the pipelined mips core
// lcg program generator, sequential isa model, instruction and data memories
// store, halt and store count checks, watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_mips_core;

   import mips_pkg::*;

   localparam int rand_len = 64;
   localparam int prog_len = rand_len + 31 + 1;
   localparam int mem_words = 128;
   // register dump lands above the 256-byte data area
   localparam int dump_base = 256;
   localparam int reset_cycles = 5;
   localparam int watchdog_cycles = prog_len * 3 + 20;

   localparam funct_e r_functs [14] = '{
      FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT,
      FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV
   };
   localparam opcode_e i_ops [7] = '{
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI
   };
   localparam opcode_e load_ops [5] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
   localparam opcode_e store_ops [3] = '{OP_SB, OP_SH, OP_SW};

   // one expected store, data already masked to its lanes
   typedef struct packed {
      word_addr_t addr;
      byte_en_t   be;
      word_t      data;
   } store_t;

   logic        clk;
   logic        rst_b;
   word_addr_t  inst_addr;
   word_t       inst;
   word_addr_t  mem_addr;
   word_t       mem_data_in;
   byte_en_t    mem_write_en;
   word_t       mem_data_out;
   logic        halted;

   word_t       imem [mem_words];
   word_t       dmem [mem_words];
   word_t       model_mem [mem_words];
   word_t       model_regs [32];
   store_t      exp_stores [$];
   int          store_count;
   logic        model_halted;
   logic [31:0] seed;
   word_addr_t  inst_idx;

   mips_core i_dut (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .mem_data_out (mem_data_out),
      .halted       (halted)
   );

   bind mips_core mips_core_assertions i_assertions (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .mem_write_en (mem_write_en),
      .halted       (halted)
   );

   always #2 clk = ~clk;

   // both memories answer in the same cycle, outside them reads are zero
   assign inst_idx     = inst_addr - text_start[31:2];
   assign inst         = (inst_idx < 30'(mem_words)) ? imem[inst_idx[6:0]] : '0;
   assign mem_data_out = (mem_addr < 30'(mem_words)) ? dmem[mem_addr[6:0]] : '0;

   function automatic int unsigned next_random();
      seed = seed * 32'd1103515245 + 32'd12345;
      // low lcg bits repeat quickly
      return {8'h00, seed[31:8]};
   endfunction

   function automatic int unsigned rand_below(input int unsigned n);
      return next_random() % n;
   endfunction

   function automatic reg_idx_t rand_reg();
      return reg_idx_t'(1 + rand_below(31));
   endfunction

   // depends on every address bit
   function automatic word_t fill_word(input int unsigned i);
      word_t v;
      v = word_t'(i);
      return (v * 32'h9e37_79b9) ^ (v << 20) ^ 32'h0f1e_2d3c;
   endfunction

   function automatic word_t expand_mask(input byte_en_t be);
      word_t m;
      for (int k = 0; k < 4; k++) begin
         m[8*k +: 8] = {8{be[k]}};
      end
      return m;
   endfunction

   function automatic logic [15:0] align_mask(input opcode_e op);
      case (op)
         OP_LH, OP_LHU, OP_SH: return 16'hfffe;
         OP_LW, OP_SW:         return 16'hfffc;
         default:              return 16'hffff;
      endcase
   endfunction

   function automatic word_t enc_r(input funct_e fn, input reg_idx_t rs, input reg_idx_t rt,
                                   input reg_idx_t rd, input logic [4:0] sh);
      return {OP_SPECIAL, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t enc_i(input opcode_e op, input reg_idx_t rs, input reg_idx_t rt,
                                   input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic report_error(input string msg);
      $display("error at %0t: %s", $time, msg);
      $display("Testbench failed");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic build_program();
      reg_idx_t    last;
      reg_idx_t    rs;
      reg_idx_t    rt;
      reg_idx_t    rd;
      opcode_e     op;
      logic [15:0] off;
      last = 5'd1;
      for (int i = 0; i < mem_words; i++) begin
         imem[i] = '0;
      end
      for (int i = 0; i < rand_len; i++) begin
         rs = rand_reg();
         rt = rand_reg();
         rd = rand_reg();
         // reuse the last destination half the time, back-to-back hazards
         if (rand_below(2) == 0) begin
            rs = last;
         end
         case (rand_below(6))
            0, 1: begin
               imem[i] = enc_r(r_functs[rand_below(14)], rs, rt, rd, 5'(rand_below(32)));
               last = rd;
            end
            2, 3: begin
               op = i_ops[rand_below(7)];
               imem[i] = enc_i(op, (op == OP_LUI) ? 5'd0 : rs, rt, 16'(next_random()));
               last = rt;
            end
            4: begin
               op = load_ops[rand_below(5)];
               off = 16'(rand_below(256)) & align_mask(op);
               imem[i] = enc_i(op, 5'd0, rt, off);
               last = rt;
            end
            default: begin
               op = store_ops[rand_below(3)];
               off = 16'(rand_below(256)) & align_mask(op);
               // store data register may be the value just produced
               imem[i] = enc_i(op, 5'd0, rs, off);
            end
         endcase
      end
      // dump r1 to r31 then stop
      for (int k = 1; k < 32; k++) begin
         imem[rand_len + k - 1] = enc_i(OP_SW, 5'd0, reg_idx_t'(k), 16'(dump_base + 4 * (k - 1)));
      end
      imem[prog_len - 1] = enc_r(FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0);
   endtask

   // executes the program one instruction at a time, recording stores
   task automatic run_model();
      word_t      w;
      word_t      a;
      word_t      b;
      word_t      r;
      word_t      simm;
      word_t      ea;
      word_t      lane;
      logic [4:0] sh;
      logic       wr;
      reg_idx_t   dst;
      byte_en_t   be;
      store_t     st;
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end
      for (int pc = 0; pc < prog_len; pc++) begin
         w    = imem[pc];
         a    = model_regs[w[25:21]];
         b    = model_regs[w[20:16]];
         sh   = w[10:6];
         simm = {{16{w[15]}}, w[15:0]};
         ea   = a + simm;
         lane = model_mem[ea[8:2]] >> {ea[1:0], 3'b000};
         r    = '0;
         wr   = 1'b1;
         dst  = w[20:16];
         be   = '0;
         case (opcode_e'(w[31:26]))
            OP_SPECIAL: begin
               dst = w[15:11];
               case (funct_e'(w[5:0]))
                  FN_ADDU: r = a + b;
                  FN_SUBU: r = a - b;
                  FN_AND:  r = a & b;
                  FN_OR:   r = a | b;
                  FN_XOR:  r = a ^ b;
                  FN_NOR:  r = ~(a | b);
                  FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  FN_SLTU: r = (a < b) ? 32'd1 : 32'd0;
                  FN_SLL:  r = b << sh;
                  FN_SRL:  r = b >> sh;
                  FN_SRA:  r = $signed(b) >>> sh;
                  FN_SLLV: r = b << a[4:0];
                  FN_SRLV: r = b >> a[4:0];
                  FN_SRAV: r = $signed(b) >>> a[4:0];
                  FN_SYSCALL: begin
                     wr = 1'b0;
                     model_halted = 1'b1;
                  end
                  default: wr = 1'b0;
               endcase
            end
            OP_ADDIU: r = a + simm;
            OP_SLTI:  r = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            OP_SLTIU: r = (a < simm) ? 32'd1 : 32'd0;
            OP_ANDI:  r = a & {16'h0000, w[15:0]};
            OP_ORI:   r = a | {16'h0000, w[15:0]};
            OP_XORI:  r = a ^ {16'h0000, w[15:0]};
            OP_LUI:   r = {w[15:0], 16'h0000};
            OP_LB:    r = {{24{lane[7]}}, lane[7:0]};
            OP_LH:    r = {{16{lane[15]}}, lane[15:0]};
            OP_LW:    r = model_mem[ea[8:2]];
            OP_LBU:   r = {24'h000000, lane[7:0]};
            OP_LHU:   r = {16'h0000, lane[15:0]};
            // byte address a sits in lane a mod 4
            OP_SB:    be = 4'b0001 << ea[1:0];
            OP_SH:    be = 4'b0011 << ea[1:0];
            OP_SW:    be = 4'b1111;
            default:  wr = 1'b0;
         endcase
         if (be != '0) begin
            wr      = 1'b0;
            st.addr = ea[31:2];
            st.be   = be;
            st.data = (b << {ea[1:0], 3'b000}) & expand_mask(be);
            exp_stores.push_back(st);
            model_mem[ea[8:2]] = (model_mem[ea[8:2]] & ~expand_mask(be)) | st.data;
         end
         if (wr && (dst != 5'd0)) begin
            model_regs[dst] = r;
         end
      end
   endtask

   task automatic check_store(input word_addr_t addr, input byte_en_t be, input word_t data);
      store_t want;
      if (exp_stores.size() == 0) begin
         report_error($sformatf("store to word %h beyond the expected stores", addr));
      end else begin
         want = exp_stores.pop_front();
         store_count++;
         if (addr !== want.addr) begin
            report_error($sformatf("store %0d address %h, expected %h", store_count, addr,
                                   want.addr));
         end else if (be !== want.be) begin
            report_error($sformatf("store %0d lanes %b, expected %b", store_count, be, want.be));
         end else if ((data & expand_mask(be)) !== want.data) begin
            report_error($sformatf("store %0d data %h, expected %h", store_count,
                                   data & expand_mask(be), want.data));
         end
      end
   endtask

   task automatic check_halt(input logic got, input logic want);
      if (got !== want) begin
         report_error($sformatf("halted is %b, expected %b", got, want));
      end
   endtask

   // stores land per lane on the edge, after being checked in order
   always @(posedge clk) begin
      if (rst_b === 1'b1) begin
         if (exp_stores.size() != 0) begin
            check_halt(halted, 1'b0);
         end
         if (mem_write_en != '0) begin
            check_store(mem_addr, mem_write_en, mem_data_in);
            for (int k = 0; k < 4; k++) begin
               if (mem_write_en[k] && (mem_addr < 30'(mem_words))) begin
                  dmem[mem_addr[6:0]][8*k +: 8] <= mem_data_in[8*k +: 8];
               end
            end
         end
      end
   end

   initial begin
      seed = 32'd61231;
      clk = 1'b0;
      rst_b <= 1'b0;
      store_count = 0;
      model_halted = 1'b0;
      for (int i = 0; i < mem_words; i++) begin
         dmem[i] <= fill_word(i);
         model_mem[i] = fill_word(i);
      end
      build_program();
      run_model();
      repeat (reset_cycles) @(posedge clk);
      rst_b <= 1'b1;
      while (halted !== 1'b1) begin
         @(posedge clk);
      end
      // a few more edges so a late store would still show up
      repeat (4) @(posedge clk);
      check_halt(halted, model_halted);
      $display("%0d stores matched the model", store_count);
      $display("Testbench passed");
      $finish;
   end

   // worst case is two stall cycles for every instruction
   initial begin
      repeat (reset_cycles + watchdog_cycles) @(posedge clk);
      $display("timeout: the core never halted within %0d cycles", watchdog_cycles);
      $display("Testbench failed");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// File: verilog.f
mips_pkg.sv
mips_fetch.sv
mips_decode.sv
mips_regfile.sv
mips_execute.sv
mips_memory_stage.sv
mips_core.sv
mips_core_assertions.sv
tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
# compile the core and testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_core -f verilog.f || exit 1
out="$(./obj_dir/Vtb_mips_core 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Testbench passed' && echo "simulation ok" || {
   echo "simulation failed"
   exit 1
}
